//--- logic/lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// store queue geometry
`define SQ_DEPTH 8
// log2 of the queue depth
`define SQ_IDX_W 3

// reorder buffer index bits
// the id carries one more wrap bit on top
`define ROB_IDX_W 5

// core word and bus width
// address and data share it
`define LSU_WORD_W 32

`endif

//--- logic/lsu_types_pkg.sv
`default_nettype none

`include "lsu_defs.svh"

package lsu_types_pkg;

   // rob id with wrap bit on top
   typedef logic [`ROB_IDX_W:0] robid_t;
   typedef logic [`LSU_WORD_W-1:0] addr_t;
   typedef logic [`LSU_WORD_W-1:0] data_t;
   typedef logic [`SQ_IDX_W-1:0] sq_idx_t;
   // free slots, saturates at 2
   typedef logic [1:0] sq_space_t;

   // store as it leaves dispatch
   typedef struct packed {
      logic   valid;
      robid_t robid;
      addr_t  base;
      addr_t  offset;
      data_t  data;
   } store_req_t;

   // store with its effective address
   typedef struct packed {
      logic   valid;
      robid_t robid;
      addr_t  addr;
      data_t  data;
   } store_entry_t;

   // one reorder buffer retire port
   typedef struct packed {
      logic   valid;
      robid_t robid;
   } retire_t;

   // true when a is strictly younger than b
   // differing wrap bits flip the index compare
   function automatic logic rob_younger(robid_t a, robid_t b);
      return (a[`ROB_IDX_W] ^ b[`ROB_IDX_W]) ^ (a[`ROB_IDX_W-1:0] > b[`ROB_IDX_W-1:0]);
   endfunction

endpackage

`default_nettype wire

//--- logic/bus_pkg.sv
`default_nettype none

`include "lsu_defs.svh"

package bus_pkg;

   typedef logic [`LSU_WORD_W-1:0] wb_adr_t;
   typedef logic [`LSU_WORD_W-1:0] wb_dat_t;

   // wishbone classic master outputs, write only
   typedef struct packed {
      logic    cyc;
      logic    stb;
      logic    we;
      wb_adr_t adr;
      wb_dat_t dat_w;
   } wb_req_t;

   // slave response, no err or rty
   typedef struct packed {
      logic    ack;
      wb_dat_t dat_r;
   } wb_rsp_t;

   // drain master states
   typedef enum logic {
      DRAIN_IDLE,
      DRAIN_BUS
   } drain_state_t;

endpackage

`default_nettype wire

//--- logic/load_forward_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module load_forward_unit (
   input  wire logic [`SQ_DEPTH-1:0]    match,
   input  wire lsu_types_pkg::sq_idx_t  alloc_ptr,
   output logic                         hit,
   output lsu_types_pkg::sq_idx_t       hit_index
);

   // walk down from the newest slot, first hit is the youngest store
   // k = SQ_DEPTH lands on alloc_ptr itself, the oldest when full
   always_comb begin
      lsu_types_pkg::sq_idx_t idx;
      hit       = 1'b0;
      hit_index = '0;
      for (int k = 1; k <= `SQ_DEPTH; k++) begin
         // index wraps in its own width
         idx = alloc_ptr - lsu_types_pkg::sq_idx_t'(k);
         if (!hit && match[idx]) begin
            hit       = 1'b1;
            hit_index = idx;
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/store_agen.sv
`timescale 1ns/1ps
`default_nettype none

module store_agen (
   input  wire logic                       clk,
   input  wire logic                       reset_n,
   input  wire lsu_types_pkg::store_req_t  req,
   input  wire logic                       flush_valid,
   input  wire lsu_types_pkg::robid_t      flush_robid,
   output lsu_types_pkg::store_entry_t     entry
);

   // effective address, full word only
   lsu_types_pkg::addr_t eff_addr;
   // stage register, payload kept apart from valid
   logic                 stage_valid;
   lsu_types_pkg::robid_t stage_robid;
   lsu_types_pkg::addr_t  stage_addr;
   lsu_types_pkg::data_t  stage_data;
   logic                 req_killed;

   assign eff_addr = req.base + req.offset;

   // store dispatched in the flush cycle but younger than the flush id
   assign req_killed = flush_valid && lsu_types_pkg::rob_younger(req.robid, flush_robid);

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         stage_valid <= 1'b0;
      end else begin
         stage_valid <= req.valid && !req_killed;
      end
   end

   // payload only loads on a live request
   always_ff @(posedge clk) begin
      if (req.valid) begin
         stage_robid <= req.robid;
         stage_addr  <= eff_addr;
         stage_data  <= req.data;
      end
   end

   // held entry is squashed by the queue if a flush hits it next
   assign entry = '{valid: stage_valid, robid: stage_robid,
                    addr: stage_addr, data: stage_data};

endmodule

`default_nettype wire

//--- logic/store_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module store_queue (
   input  wire logic                         clk,
   input  wire logic                         reset_n,
   input  wire lsu_types_pkg::store_entry_t  in_entry,
   input  wire lsu_types_pkg::retire_t       retire0,
   input  wire lsu_types_pkg::retire_t       retire1,
   input  wire logic                         flush_valid,
   input  wire lsu_types_pkg::robid_t        flush_robid,
   input  wire lsu_types_pkg::addr_t         load_addr,
   output logic                              fwd_valid,
   output lsu_types_pkg::data_t              fwd_data,
   output lsu_types_pkg::sq_space_t          sq_space,
   output lsu_types_pkg::store_entry_t       drain_entry,
   input  wire logic                         take
);

   // occupancy count, one bit wider than the index
   typedef logic [`SQ_IDX_W:0] sq_cnt_t;

   // per-entry payload, no reset
   lsu_types_pkg::robid_t sq_robid [`SQ_DEPTH];
   lsu_types_pkg::addr_t  sq_addr  [`SQ_DEPTH];
   lsu_types_pkg::data_t  sq_data  [`SQ_DEPTH];
   // control flags
   logic [`SQ_DEPTH-1:0]  sq_valid;
   logic [`SQ_DEPTH-1:0]  sq_commit;
   logic [`SQ_DEPTH-1:0]  sq_valid_nxt;
   logic [`SQ_DEPTH-1:0]  sq_commit_nxt;
   lsu_types_pkg::sq_idx_t alloc_ptr;
   lsu_types_pkg::sq_idx_t tail_ptr;
   lsu_types_pkg::sq_idx_t tail_nxt;
   sq_cnt_t               occ_now;
   sq_cnt_t               occ_nxt;
   sq_cnt_t               free_slots;
   logic                  in_kill;
   logic                  in_retired;
   logic                  do_alloc;
   logic [`SQ_DEPTH-1:0]  load_match;
   lsu_types_pkg::sq_idx_t fwd_index;

   // id matches either live retire port
   function automatic logic retire_hit(lsu_types_pkg::robid_t id,
                                       lsu_types_pkg::retire_t r0,
                                       lsu_types_pkg::retire_t r1);
      return (r0.valid && (r0.robid == id)) || (r1.valid && (r1.robid == id));
   endfunction

   // incoming entry from the address stage
   assign in_kill    = flush_valid && lsu_types_pkg::rob_younger(in_entry.robid, flush_robid);
   assign in_retired = retire_hit(in_entry.robid, retire0, retire1);
   assign do_alloc   = in_entry.valid && !in_kill;

   always_comb begin
      sq_valid_nxt  = sq_valid;
      sq_commit_nxt = sq_commit;
      tail_nxt      = tail_ptr;
      for (int i = 0; i < `SQ_DEPTH; i++) begin
         // retire marks commit
         if (sq_valid[i] && retire_hit(sq_robid[i], retire0, retire1)) begin
            sq_commit_nxt[i] = 1'b1;
         end
         // flush squashes younger, not yet committed
         if (flush_valid && sq_valid[i] && !sq_commit[i] &&
             lsu_types_pkg::rob_younger(sq_robid[i], flush_robid)) begin
            sq_valid_nxt[i] = 1'b0;
         end
      end
      // tail handed to the drain master
      if (take) begin
         sq_valid_nxt[tail_ptr]  = 1'b0;
         sq_commit_nxt[tail_ptr] = 1'b0;
         tail_nxt                = tail_ptr + 1'b1;
      end
      if (do_alloc) begin
         sq_valid_nxt[alloc_ptr]  = 1'b1;
         sq_commit_nxt[alloc_ptr] = in_retired;
      end
   end

   // entries have no holes, so alloc = tail + count
   always_comb begin
      occ_now = '0;
      occ_nxt = '0;
      for (int i = 0; i < `SQ_DEPTH; i++) begin
         occ_now = occ_now + sq_cnt_t'(sq_valid[i]);
         occ_nxt = occ_nxt + sq_cnt_t'(sq_valid_nxt[i]);
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         sq_valid  <= '0;
         sq_commit <= '0;
         alloc_ptr <= '0;
         tail_ptr  <= '0;
      end else begin
         sq_valid  <= sq_valid_nxt;
         sq_commit <= sq_commit_nxt;
         tail_ptr  <= tail_nxt;
         alloc_ptr <= tail_nxt + occ_nxt[`SQ_IDX_W-1:0];
      end
   end

   always_ff @(posedge clk) begin
      if (do_alloc) begin
         sq_robid[alloc_ptr] <= in_entry.robid;
         sq_addr[alloc_ptr]  <= in_entry.addr;
         sq_data[alloc_ptr]  <= in_entry.data;
      end
   end

   // stage entry counts against space so nothing in flight is lost
   assign free_slots = sq_cnt_t'(`SQ_DEPTH) - occ_now - sq_cnt_t'(in_entry.valid);
   assign sq_space   = (free_slots >= sq_cnt_t'(2)) ? 2'd2 : free_slots[1:0];

   // drain offer, only once retired
   assign drain_entry = '{valid: sq_valid[tail_ptr] && sq_commit[tail_ptr],
                          robid: sq_robid[tail_ptr],
                          addr:  sq_addr[tail_ptr],
                          data:  sq_data[tail_ptr]};

   // address compare against every resident entry
   always_comb begin
      for (int i = 0; i < `SQ_DEPTH; i++) begin
         load_match[i] = sq_valid[i] && (sq_addr[i] == load_addr);
      end
   end

   load_forward_unit u_fwd_pick (
      .match     (load_match),
      .alloc_ptr (alloc_ptr),
      .hit       (fwd_valid),
      .hit_index (fwd_index)
   );

   assign fwd_data = sq_data[fwd_index];

endmodule

`default_nettype wire

//--- logic/store_drain_wb.sv
`timescale 1ns/1ps
`default_nettype none

module store_drain_wb (
   input  wire logic                         clk,
   input  wire logic                         reset_n,
   input  wire lsu_types_pkg::store_entry_t  drain_entry,
   output logic                              take,
   output bus_pkg::wb_req_t                  wb_req,
   input  wire bus_pkg::wb_rsp_t             wb_rsp
);

   bus_pkg::drain_state_t state;
   // store held for the whole bus cycle
   bus_pkg::wb_adr_t      hold_adr;
   bus_pkg::wb_dat_t      hold_dat;

   // accept only when idle, never on the ack edge
   assign take = (state == bus_pkg::DRAIN_IDLE) && drain_entry.valid;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state <= bus_pkg::DRAIN_IDLE;
      end else begin
         case (state)
            bus_pkg::DRAIN_IDLE: begin
               if (take) begin
                  state <= bus_pkg::DRAIN_BUS;
               end
            end
            bus_pkg::DRAIN_BUS: begin
               // one write per cycle, ends at ack
               if (wb_rsp.ack) begin
                  state <= bus_pkg::DRAIN_IDLE;
               end
            end
            default: state <= bus_pkg::DRAIN_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         hold_adr <= drain_entry.addr;
         hold_dat <= drain_entry.data;
      end
   end

   // cyc, stb and we follow the state
   always_comb begin
      wb_req.cyc   = (state == bus_pkg::DRAIN_BUS);
      wb_req.stb   = (state == bus_pkg::DRAIN_BUS);
      wb_req.we    = (state == bus_pkg::DRAIN_BUS);
      wb_req.adr   = hold_adr;
      wb_req.dat_w = hold_dat;
   end

endmodule

`default_nettype wire

//--- logic/lsu_store_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_store_top (
   input  wire logic                         clk,
   input  wire logic                         reset_n,
   // dispatch
   input  wire lsu_types_pkg::store_req_t    req,
   // retire ports
   input  wire lsu_types_pkg::retire_t       retire0,
   input  wire lsu_types_pkg::retire_t       retire1,
   // flush
   input  wire logic                         flush_valid,
   input  wire lsu_types_pkg::robid_t        flush_robid,
   // load forwarding
   input  wire lsu_types_pkg::addr_t         load_addr,
   output logic                              fwd_valid,
   output lsu_types_pkg::data_t              fwd_data,
   output lsu_types_pkg::sq_space_t          sq_space,
   // wishbone master
   output bus_pkg::wb_req_t                  wb_req,
   input  wire bus_pkg::wb_rsp_t             wb_rsp
);

   // address stage to queue
   lsu_types_pkg::store_entry_t agen_entry;
   // queue tail to drain master
   lsu_types_pkg::store_entry_t drain_entry;
   logic                        take;

   store_agen u_agen (
      .clk         (clk),
      .reset_n     (reset_n),
      .req         (req),
      .flush_valid (flush_valid),
      .flush_robid (flush_robid),
      .entry       (agen_entry)
   );

   store_queue u_sq (
      .clk         (clk),
      .reset_n     (reset_n),
      .in_entry    (agen_entry),
      .retire0     (retire0),
      .retire1     (retire1),
      .flush_valid (flush_valid),
      .flush_robid (flush_robid),
      .load_addr   (load_addr),
      .fwd_valid   (fwd_valid),
      .fwd_data    (fwd_data),
      .sq_space    (sq_space),
      .drain_entry (drain_entry),
      .take        (take)
   );

   store_drain_wb u_drain (
      .clk         (clk),
      .reset_n     (reset_n),
      .drain_entry (drain_entry),
      .take        (take),
      .wb_req      (wb_req),
      .wb_rsp      (wb_rsp)
   );

endmodule

`default_nettype wire

//--- verif/lsu_store_chk.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_store_chk (
   input wire logic                     clk,
   input wire logic                     reset_n,
   input wire bus_pkg::wb_req_t         wb_req,
   input wire bus_pkg::wb_rsp_t         wb_rsp,
   input wire logic                     stage_valid,
   input wire lsu_types_pkg::sq_space_t sq_space
);

   // failed assertions, read back at the end of the run
   int unsigned fail_count = 0;

   // strobe only inside a bus cycle
   a_stb_in_cyc: assert property (@(posedge clk) disable iff (!reset_n)
      wb_req.stb |-> wb_req.cyc)
      else begin
         $error("stb high outside a bus cycle");
         fail_count++;
      end

   // write held steady until the slave acks
   a_hold_write: assert property (@(posedge clk) disable iff (!reset_n)
      (wb_req.stb && !wb_rsp.ack) |=> ($stable(wb_req.adr) && $stable(wb_req.dat_w)))
      else begin
         $error("address or data changed before ack");
         fail_count++;
      end

   // stage only fills from a dispatch made while space was reported
   a_no_full_dispatch: assert property (@(posedge clk) disable iff (!reset_n)
      stage_valid |-> ($past(sq_space) != 2'd0))
      else begin
         $error("store dispatched while the queue reported no space");
         fail_count++;
      end

   // bus idle right after a reset edge
   a_reset_idle: assert property (@(posedge clk) !reset_n |=> !wb_req.cyc)
      else begin
         $error("cyc high in the cycle after reset");
         fail_count++;
      end

endmodule

// drain master, no queue view here
bind store_drain_wb lsu_store_chk chk_i (
   .clk         (clk),
   .reset_n     (reset_n),
   .wb_req      (wb_req),
   .wb_rsp      (wb_rsp),
   .stage_valid (1'b0),
   .sq_space    (2'd2)
);

// queue, bus side held idle
bind store_queue lsu_store_chk chk_i (
   .clk         (clk),
   .reset_n     (reset_n),
   .wb_req      ('0),
   .wb_rsp      ('0),
   .stage_valid (in_entry.valid),
   .sq_space    (sq_space)
);

`default_nettype wire

//--- verif/lsu_store_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_store_tb;

   // stores issued over all tests set the watchdog length
   localparam int NUM_STORES = 31;
   localparam int MAX_ST     = 64;
   localparam int WATCHDOG   = NUM_STORES * 20 + 2000;

   logic                      clk;
   logic                      reset_n;
   lsu_types_pkg::store_req_t req;
   lsu_types_pkg::retire_t    retire0;
   lsu_types_pkg::retire_t    retire1;
   logic                      flush_valid;
   lsu_types_pkg::robid_t     flush_robid;
   lsu_types_pkg::addr_t      load_addr;
   logic                      fwd_valid;
   lsu_types_pkg::data_t      fwd_data;
   lsu_types_pkg::sq_space_t  sq_space;
   bus_pkg::wb_req_t          wb_req;
   bus_pkg::wb_rsp_t          wb_rsp;

   // model store list in program order
   lsu_types_pkg::robid_t m_robid [MAX_ST];
   lsu_types_pkg::addr_t  m_addr  [MAX_ST];
   lsu_types_pkg::data_t  m_data  [MAX_ST];
   bit                    m_commit  [MAX_ST];
   bit                    m_flushed [MAX_ST];
   bit                    m_written [MAX_ST];
   int                    n_st;
   // writes seen by the memory model in bus order
   lsu_types_pkg::addr_t  log_adr [$];
   lsu_types_pkg::data_t  log_dat [$];
   int                    ack_wait;
   bit                    long_ack;
   int                    errors;
   int                    test_errors;
   string                 test_name;

   lsu_store_top dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // oldest store still headed for the bus or -1
   function automatic int oldest_live();
      for (int i = 0; i < n_st; i++) begin
         if (!m_flushed[i] && !m_written[i]) begin
            return i;
         end
      end
      return -1;
   endfunction

   // youngest resident store at this address or -1
   function automatic int youngest_match(lsu_types_pkg::addr_t a);
      for (int i = n_st - 1; i >= 0; i--) begin
         if (!m_flushed[i] && !m_written[i] && m_addr[i] == a) begin
            return i;
         end
      end
      return -1;
   endfunction

   task automatic check_addr(string what, lsu_types_pkg::addr_t exp, lsu_types_pkg::addr_t act);
      if (act !== exp) begin
         $display("Error %s %s: expected %h, actual %h", test_name, what, exp, act);
         test_errors++;
      end
   endtask

   task automatic check_data(string what, lsu_types_pkg::data_t exp, lsu_types_pkg::data_t act);
      if (act !== exp) begin
         $display("Error %s %s: expected %h, actual %h", test_name, what, exp, act);
         test_errors++;
      end
   endtask

   task automatic check_space(string what, lsu_types_pkg::sq_space_t exp,
                              lsu_types_pkg::sq_space_t act);
      if (act !== exp) begin
         $display("Error %s %s: expected %0d, actual %0d", test_name, what, exp, act);
         test_errors++;
      end
   endtask

   task automatic check_flag(string what, logic exp, logic act);
      if (act !== exp) begin
         $display("Error %s %s: expected %b, actual %b", test_name, what, exp, act);
         test_errors++;
      end
   endtask

   // wishbone slave with a random ack delay logs each write on its ack
   always @(posedge clk) begin
      if (!reset_n) begin
         wb_rsp.ack <= 1'b0;
         ack_wait   <= 0;
      end else if (wb_rsp.ack) begin
         wb_rsp.ack <= 1'b0;
      end else if (wb_req.cyc && wb_req.stb) begin
         if (ack_wait == 0) begin
            wb_rsp.ack <= 1'b1;
            // every bus cycle of the drain master is a write
            check_flag("bus we", 1'b1, wb_req.we);
            log_adr.push_back(wb_req.adr);
            log_dat.push_back(wb_req.dat_w);
            ack_wait <= long_ack ? 15 + $urandom % 11 : $urandom % 6;
         end else begin
            ack_wait <= ack_wait - 1;
         end
      end
   end

   // each write has to be the oldest live store and retired
   always @(negedge clk) begin
      int idx;
      while (log_adr.size() > 0) begin
         idx = oldest_live();
         if (idx < 0 || !m_commit[idx]) begin
            $display("%s: bus write to %h with no retired store waiting", test_name, log_adr[0]);
            test_errors++;
         end else begin
            check_addr("bus address", m_addr[idx], log_adr[0]);
            check_data("bus data", m_data[idx], log_dat[0]);
            m_written[idx] = 1'b1;
         end
         void'(log_adr.pop_front());
         void'(log_dat.pop_front());
      end
   end

   // drives one store and leaves a cycle so space is read before the next
   task automatic dispatch(lsu_types_pkg::addr_t base, lsu_types_pkg::addr_t offset);
      @(negedge clk);
      while (sq_space == 2'd0) begin
         @(negedge clk);
      end
      @(posedge clk);
      m_robid[n_st] = lsu_types_pkg::robid_t'(50 + n_st);
      m_addr[n_st]  = base + offset;
      m_data[n_st]  = $urandom;
      req <= '{valid: 1'b1, robid: m_robid[n_st], base: base, offset: offset,
               data: m_data[n_st]};
      n_st++;
      @(posedge clk);
      req.valid <= 1'b0;
   endtask

   // b < 0 leaves port 1 idle
   task automatic retire(int a, int b);
      @(posedge clk);
      retire0     <= '{valid: 1'b1, robid: m_robid[a]};
      m_commit[a] = 1'b1;
      if (b >= 0) begin
         retire1     <= '{valid: 1'b1, robid: m_robid[b]};
         m_commit[b] = 1'b1;
      end
      @(posedge clk);
      retire0.valid <= 1'b0;
      retire1.valid <= 1'b0;
   endtask

   // called on the edge after a dispatch while the last store sits in the stage
   task automatic flush_after(int idx);
      flush_valid <= 1'b1;
      flush_robid <= m_robid[idx];
      for (int i = idx + 1; i < n_st; i++) begin
         if (!m_commit[i]) begin
            m_flushed[i] = 1'b1;
         end
      end
      @(posedge clk);
      flush_valid <= 1'b0;
   endtask

   task automatic check_forward(lsu_types_pkg::addr_t a);
      int idx;
      @(posedge clk);
      load_addr <= a;
      @(negedge clk);
      idx = youngest_match(a);
      check_flag("fwd_valid", idx >= 0, fwd_valid);
      if (idx >= 0) begin
         check_data("fwd_data", m_data[idx], fwd_data);
      end
   endtask

   task automatic wait_drained();
      int cycles;
      cycles = 0;
      while (oldest_live() >= 0 && cycles < 2000) begin
         @(posedge clk);
         cycles++;
      end
      // last ack and cyc drop
      repeat (3) @(posedge clk);
      if (cycles >= 2000) begin
         $display("%s: retired stores never drained to the bus", test_name);
         test_errors++;
      end
   endtask

   task automatic start_test(string name);
      test_name   = name;
      test_errors = 0;
   endtask

   task automatic end_test();
      $display("test %s: %s, %0d errors", test_name, (test_errors == 0) ? "ok" : "failed",
               test_errors);
      errors += test_errors;
   endtask

   initial begin
      int first;
      int left;
      void'($urandom(39));
      req         = '0;
      retire0     = '0;
      retire1     = '0;
      flush_valid = 1'b0;
      flush_robid = '0;
      load_addr   = '0;
      wb_rsp      = '0;
      long_ack    = 1'b0;
      n_st        = 0;
      errors      = 0;
      start_test("reset");
      reset_n = 1'b0;
      repeat (4) @(posedge clk);
      reset_n <= 1'b1;
      @(posedge clk);

      // retired stores leave in dispatch order
      start_test("in_order");
      first = n_st;
      for (int i = 0; i < 6; i++) begin
         dispatch(32'h1000_0000 + i * 64, ($urandom % 16) * 4);
      end
      for (int i = 0; i < 6; i++) begin
         retire(first + i, -1);
      end
      wait_drained();
      end_test();

      // three stores share 2000_0040
      start_test("forward");
      first = n_st;
      dispatch(32'h2000_0000, 32'h40);
      dispatch(32'h2000_0100, 32'h0);
      dispatch(32'h2000_0020, 32'h20);
      dispatch(32'h2000_0200, 32'h4);
      dispatch(32'h2000_0030, 32'h10);
      check_forward(32'h2000_0040);
      check_forward(32'h2000_0100);
      check_forward(32'h2000_0300);
      retire(first, first + 1);
      retire(first + 2, first + 3);
      retire(first + 4, -1);
      wait_drained();
      check_forward(32'h2000_0040);
      end_test();

      // flush names the third store and the ids wrap inside this group
      start_test("flush");
      first = n_st;
      dispatch(32'h3000_0000, 32'h8);
      dispatch(32'h3000_0100, 32'h0);
      dispatch(32'h3000_0200, 32'h0);
      dispatch(32'h3000_0004, 32'h4);
      dispatch(32'h3000_0300, 32'h0);
      dispatch(32'h3000_0400, 32'h0);
      flush_after(first + 2);
      check_forward(32'h3000_0008);
      check_forward(32'h3000_0400);
      retire(first, first + 1);
      retire(first + 2, -1);
      wait_drained();
      end_test();

      start_test("dual_retire");
      first = n_st;
      dispatch(32'h4000_0000, ($urandom % 64) * 4);
      dispatch(32'h4000_1000, ($urandom % 64) * 4);
      retire(first, first + 1);
      wait_drained();
      end_test();

      // slow acks fill the queue and dispatch waits while it drains
      start_test("back_pressure");
      long_ack = 1'b1;
      first    = n_st;
      for (int i = 0; i < `SQ_DEPTH; i++) begin
         dispatch(32'h5000_0000 + i * 16, 32'h0);
         @(negedge clk);
         left = `SQ_DEPTH - 1 - i;
         check_space("sq_space", (left >= 2) ? 2'd2 : 2'(left), sq_space);
      end
      fork
         for (int i = `SQ_DEPTH; i < 12; i++) begin
            dispatch(32'h5000_0000 + i * 16, 32'h0);
         end
         for (int i = 0; i < 12; i++) begin
            wait (n_st > first + i);
            repeat (2) @(posedge clk);
            retire(first + i, -1);
         end
      join
      wait_drained();
      long_ack = 1'b0;
      @(negedge clk);
      check_space("sq_space after drain", 2'd2, sq_space);
      end_test();

      left = dut_i.u_drain.chk_i.fail_count + dut_i.u_sq.chk_i.fail_count;
      if (left > 0) begin
         $display("%0d bus or queue assertions failed", left);
      end
      errors += left;
      $display("5 tests run, %0d errors", errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG) @(posedge clk);
      $display("watchdog: run did not end within %0d cycles", WATCHDOG);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- lsu_store_top.f
+incdir+logic
logic/lsu_types_pkg.sv
logic/bus_pkg.sv
logic/load_forward_unit.sv
logic/store_agen.sv
logic/store_queue.sv
logic/store_drain_wb.sv
logic/lsu_store_top.sv
verif/lsu_store_chk.sv
verif/lsu_store_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile the store unit testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps --top-module lsu_store_tb \
   -f lsu_store_top.f -o lsu_store_sim > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/lsu_store_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

! grep -q "Simulation finished: FAIL" sim.log && grep -q "Simulation finished: PASS" sim.log \
   && echo "run passed" \
   || { echo "run failed"; exit 1; }
